//--- common/noc_pkg.sv
package noc_pkg;

    // Fixed 2x2 mesh
    localparam int NUM_NODES = 4;
    // Endpoint, horizontal neighbour, vertical neighbour
    localparam int NUM_PORTS = 3;
    localparam int NUM_VCS = 2;

    localparam int NODE_W = 2;
    localparam int VC_W = 1;
    localparam int PAYLOAD_W = 16;
    // Width of an output port index
    localparam int PORT_W = $clog2(NUM_PORTS);

    // Routing header, set by the source and kept on every hop
    typedef struct packed {
        logic [NODE_W-1:0] dest;
        logic [VC_W-1:0]   vc;
    } metadata_t;

    typedef struct packed {
        metadata_t            metadata;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // Dimension-ordered routing
    // Node bit 0 is the column, bit 1 the row
    function automatic logic [PORT_W-1:0] route_port(
        input logic [NODE_W-1:0] node,
        input logic [NODE_W-1:0] dest
    );
        // Resolve the column first
        if (node[0] != dest[0]) begin
            return PORT_W'(1);
        end
        // Then the row
        if (node[1] != dest[1]) begin
            return PORT_W'(2);
        end
        // Arrived, eject to the endpoint
        return PORT_W'(0);
    endfunction

endpackage

//--- common/switch_if.sv
`timescale 1ns/1ps

interface switch_if;
    import noc_pkg::*;

    // Link inputs, one entry per port
    flit_t in [NUM_PORTS];
    // Strobe, in[p] is valid this cycle
    logic data_ready_in [NUM_PORTS];
    // Per-VC free slot level of each input port
    logic [NUM_VCS-1:0] buffer_available [NUM_PORTS];

    // Link outputs, one entry per port
    flit_t out [NUM_PORTS];
    logic data_ready_out [NUM_PORTS];
    // Receiver side of out[p] can take VC v
    logic [NUM_VCS-1:0] credit_granted [NUM_PORTS];
    // out[p] was taken this cycle
    logic packet_sent [NUM_PORTS];

    // Endpoint injection buffers were read this cycle
    logic inject_read;

    modport sw (
        input  in,
        input  data_ready_in,
        output buffer_available,
        output out,
        output data_ready_out,
        input  credit_granted,
        input  packet_sent,
        output inject_read
    );

    modport fabric (
        output in,
        output data_ready_in,
        input  buffer_available,
        input  out,
        input  data_ready_out,
        output credit_granted,
        output packet_sent,
        input  inject_read
    );

endinterface

//--- switch/vc_buffer.sv
`timescale 1ns/1ps

module vc_buffer #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  noc_pkg::flit_t wr_flit,
    input  logic           rd_en,
    output noc_pkg::flit_t head,
    output logic           not_empty,
    output logic           available
);
    import noc_pkg::*;

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    flit_t mem [BUFFER_SIZE];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // Occupancy including the flit arriving this cycle
    logic [CNT_W:0]   fill;

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    // Pointers wrap at BUFFER_SIZE, size need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // The flit on the link is already committed, so the slot granted now
    // must come on top of it
    assign fill      = {1'b0, count} + (CNT_W + 1)'(wr_en);
    assign available = (fill < (CNT_W + 1)'(BUFFER_SIZE));

    // Overflow would mean the upstream credit check was bypassed
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (count < CNT_W'(BUFFER_SIZE)) || rd_en)
        else $error("vc_buffer: write into a full buffer");

    assert property (@(posedge clk) disable iff (rst)
        rd_en |-> not_empty)
        else $error("vc_buffer: read from an empty buffer");

endmodule

//--- switch/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator (
    input  logic clk,
    input  logic rst,
    input  logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VCS-1:0] request,
    output logic [noc_pkg::NUM_PORTS*noc_pkg::NUM_VCS-1:0] grant
);
    import noc_pkg::*;

    // Request index is input_port*NUM_VCS + vc
    localparam int NUM_REQ = NUM_PORTS * NUM_VCS;
    localparam int IDX_W = $clog2(NUM_REQ);

    // Highest priority request this cycle
    logic [IDX_W-1:0] prio;
    logic [IDX_W-1:0] winner;
    logic             found;

    // Scan from prio upward and wrap, first hit wins
    always_comb begin : pick
        int idx;
        grant  = '0;
        winner = prio;
        found  = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            idx = (int'(prio) + i) % NUM_REQ;
            if (!found && request[idx]) begin
                found  = 1'b1;
                winner = IDX_W'(idx);
            end
        end
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    // Pointer moves just past the winner, so it drops to lowest priority
    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= '0;
        end else if (found) begin
            if (winner == IDX_W'(NUM_REQ - 1)) begin
                prio <= '0;
            end else begin
                prio <= winner + 1'b1;
            end
        end
    end

    // Same winner twice running only when nobody else asks
    assert property (@(posedge clk) disable iff (rst)
        (grant != '0) && (grant == $past(grant)) |-> (request == grant))
        else $error("switch_allocator: grant %b repeated over request %b",
                    grant, request);

endmodule

//--- switch/switch.sv
`timescale 1ns/1ps

module switch #(
    parameter int NODE_ID = 0,
    parameter int BUFFER_SIZE = 8
) (
    input logic  clk,
    input logic  rst,
    switch_if.sw sw_if
);
    import noc_pkg::*;

    // Input port/VC pair index is p*NUM_VCS + v
    localparam int NUM_REQ = NUM_PORTS * NUM_VCS;

    flit_t              head [NUM_REQ];
    logic [NUM_REQ-1:0] not_empty;
    logic [NUM_REQ-1:0] eligible;
    logic [NUM_REQ-1:0] rd_en;
    logic [PORT_W-1:0]  dest_port [NUM_REQ];

    // One VC per input port goes to the allocators each cycle
    logic [VC_W-1:0]      vc_pri [NUM_PORTS];
    logic [VC_W-1:0]      sel_vc [NUM_PORTS];
    logic [NUM_PORTS-1:0] sel_valid;

    logic [NUM_REQ-1:0] request [NUM_PORTS];
    logic [NUM_REQ-1:0] grant [NUM_PORTS];

    // Registered output links
    flit_t                out_q [NUM_PORTS];
    flit_t                out_next [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_free;
    logic [NUM_PORTS-1:0] out_load;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            localparam int R = p * NUM_VCS + v;

            // Arriving flit goes to the buffer of its own VC
            vc_buffer #(
                .BUFFER_SIZE(BUFFER_SIZE)
            ) u_vc_buffer (
                .clk       (clk),
                .rst       (rst),
                .wr_en     (sw_if.data_ready_in[p] && sw_if.in[p].metadata.vc == VC_W'(v)),
                .wr_flit   (sw_if.in[p]),
                .rd_en     (rd_en[R]),
                .head      (head[R]),
                .not_empty (not_empty[R]),
                .available (sw_if.buffer_available[p][v])
            );

            assign dest_port[R] = route_port(NODE_W'(NODE_ID), head[R].metadata.dest);
            // Head may move if its output register frees up and the next hop has room
            assign eligible[R] = not_empty[R] && out_free[dest_port[R]]
                                 && sw_if.credit_granted[dest_port[R]][v];

            // Upstream only sends on a VC it saw available the cycle before
            assert property (@(posedge clk) disable iff (rst)
                (sw_if.data_ready_in[p] && sw_if.in[p].metadata.vc == VC_W'(v))
                |-> $past(sw_if.buffer_available[p][v]))
                else $error("switch %0d: flit on port %0d vc %0d without space",
                            NODE_ID, p, v);
        end

        // Register is free when empty or being taken this cycle
        assign out_free[p] = !out_valid[p] || sw_if.packet_sent[p];

        switch_allocator u_switch_allocator (
            .clk     (clk),
            .rst     (rst),
            .request (request[p]),
            .grant   (grant[p])
        );

        assign sw_if.out[p]            = out_q[p];
        assign sw_if.data_ready_out[p] = out_valid[p];
    end

    // Round robin over the VCs of each input port
    always_comb begin : vc_select
        int v;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sel_valid[p] = 1'b0;
            sel_vc[p]    = vc_pri[p];
            for (int i = 0; i < NUM_VCS; i++) begin
                v = (int'(vc_pri[p]) + i) % NUM_VCS;
                if (!sel_valid[p] && eligible[p * NUM_VCS + v]) begin
                    sel_valid[p] = 1'b1;
                    sel_vc[p]    = VC_W'(v);
                end
            end
        end
    end

    // Masked requests, each selected head asks only its routed output
    always_comb begin : requests
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int r = 0; r < NUM_REQ; r++) begin
                request[o][r] = eligible[r] && sel_valid[r / NUM_VCS]
                                && sel_vc[r / NUM_VCS] == VC_W'(r % NUM_VCS)
                                && dest_port[r] == PORT_W'(o);
            end
        end
    end

    // Crossbar and buffer reads from the grants
    always_comb begin : crossbar
        rd_en = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_next[o] = '0;
            out_load[o] = |grant[o];
            for (int r = 0; r < NUM_REQ; r++) begin
                if (grant[o][r]) begin
                    out_next[o] = head[r];
                    rd_en[r]    = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                vc_pri[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Load wins over drain, back to back flits keep valid high
                if (out_load[p]) begin
                    out_valid[p] <= 1'b1;
                end else if (sw_if.packet_sent[p]) begin
                    out_valid[p] <= 1'b0;
                end
                if (|rd_en[p * NUM_VCS +: NUM_VCS]) begin
                    vc_pri[p] <= (sel_vc[p] == VC_W'(NUM_VCS - 1)) ? '0 : sel_vc[p] + 1'b1;
                end
            end
        end
    end

    // Payload held while blocked
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (out_load[p]) begin
                out_q[p] <= out_next[p];
            end
        end
    end

    // Port 0 reads return a credit to the endpoint
    assign sw_if.inject_read = |rd_en[NUM_VCS-1:0];

endmodule

//--- hw/switch_wrapper.sv
`timescale 1ns/1ps

module switch_wrapper #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic           clk,
    input  logic           rst,
    // Flits injected by the endpoints
    input  noc_pkg::flit_t in_flit [noc_pkg::NUM_NODES-1:0],
    input  logic           data_ready_in [noc_pkg::NUM_NODES-1:0],
    input  logic           packet_sent [noc_pkg::NUM_NODES-1:0],
    // Flits ejected to the endpoints
    output noc_pkg::flit_t out [noc_pkg::NUM_NODES-1:0],
    output logic           data_ready_out [noc_pkg::NUM_NODES-1:0],
    output logic           buffer_available [noc_pkg::NUM_NODES*2-1:0],
    output logic           credit_granted [noc_pkg::NUM_NODES-1:0]
);
    import noc_pkg::*;

    // Mesh, node n at column n[0] and row n[1]
    //
    //   node 0 <--port 1--> node 1
    //     ^                   ^
    //   port 2              port 2
    //     v                   v
    //   node 2 <--port 1--> node 3
    //
    // Links are symmetric, the neighbour answers on the same port number

    switch_if sw_if [NUM_NODES] ();

    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        switch #(
            .NODE_ID     (n),
            .BUFFER_SIZE (BUFFER_SIZE)
        ) u_switch (
            .clk   (clk),
            .rst   (rst),
            .sw_if (sw_if[n])
        );

        // Endpoint side on port 0
        assign sw_if[n].in[0]            = in_flit[n];
        assign sw_if[n].data_ready_in[0] = data_ready_in[n];
        // Output register is the only storage towards the endpoint
        assign sw_if[n].credit_granted[0] = '1;
        assign sw_if[n].packet_sent[0]    = sw_if[n].data_ready_out[0] & packet_sent[n];

        assign out[n]            = sw_if[n].out[0];
        assign data_ready_out[n] = sw_if[n].data_ready_out[0];
        assign credit_granted[n] = sw_if[n].inject_read;

        // VC v of node n sits at v*NUM_NODES + n
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_avail
            assign buffer_available[v * NUM_NODES + n] = sw_if[n].buffer_available[0][v];
        end

        // Port 1 flips the column bit, port 2 the row bit
        for (genvar p = 1; p < NUM_PORTS; p++) begin : g_link
            localparam int NB = n ^ p;

            assign sw_if[n].in[p]             = sw_if[NB].out[p];
            assign sw_if[n].data_ready_in[p]  = sw_if[NB].data_ready_out[p];
            assign sw_if[n].credit_granted[p] = sw_if[NB].buffer_available[p];
            // Neighbour always takes what it was granted space for
            assign sw_if[n].packet_sent[p]    = sw_if[n].data_ready_out[p];
        end
    end

endmodule

//--- testbench/switch_wrapper_tb.sv
`timescale 1ns/1ps

module switch_wrapper_tb;
    import noc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int BUFFER_SIZE = 8;
    localparam int NUM_QUEUES = NUM_NODES * NUM_NODES * NUM_VCS;
    localparam int MAX_FLITS = 128;
    // Flits per test
    localparam int ROUTE_FLITS = NUM_NODES * NUM_NODES * NUM_VCS;
    localparam int RAND_PER_NODE = 48;
    localparam int BP_PER_NODE = 40;
    localparam int TOTAL_FLITS = ROUTE_FLITS + NUM_NODES * RAND_PER_NODE + 3 * BP_PER_NODE;
    // Generous bound per flit, covers the blocked phase too
    localparam int CYCLES_PER_FLIT = 20;
    localparam int WATCHDOG_NS = (TOTAL_FLITS * CYCLES_PER_FLIT + 100) * CLK_PERIOD;
    // Extra cycles the sink stays blocked once sources stall
    localparam int BLOCK_HOLD = 20;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    flit_t in_flit [NUM_NODES-1:0] = '{default: '0};
    logic  data_ready_in [NUM_NODES-1:0] = '{default: 1'b0};
    logic  packet_sent [NUM_NODES-1:0] = '{default: 1'b0};
    flit_t out [NUM_NODES-1:0];
    logic  data_ready_out [NUM_NODES-1:0];
    logic  buffer_available [NUM_NODES*2-1:0];
    logic  credit_granted [NUM_NODES-1:0];

    // Traffic list per source, appended by the test sequence
    flit_t stim [NUM_NODES][MAX_FLITS];
    int    stim_len [NUM_NODES];
    int    sent_idx [NUM_NODES];
    logic  sink_blocked [NUM_NODES] = '{default: 1'b0};
    // Scoreboard, one queue per (source, destination, VC)
    flit_t sb_q [NUM_QUEUES][$];

    int    rx_cnt;
    int    credit_cnt [NUM_NODES];
    int    low_cnt [NUM_NODES*2];
    int    cmp_errors;
    int    hold_errors;
    int    test_errors;
    int    err_base;
    int    rx_base;
    logic  stall_valid [NUM_NODES] = '{default: 1'b0};
    flit_t stall_flit [NUM_NODES];
    int    seed = 32'hd6d20e81;

    switch_wrapper #(
        .BUFFER_SIZE (BUFFER_SIZE)
    ) switch_wrapper_inst (
        .clk              (clk),
        .rst              (rst),
        .in_flit          (in_flit),
        .data_ready_in    (data_ready_in),
        .packet_sent      (packet_sent),
        .out              (out),
        .data_ready_out   (data_ready_out),
        .buffer_available (buffer_available),
        .credit_granted   (credit_granted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Dimension-ordered walk, column first, then row
    function automatic int expected_eject(input int src, input int dst);
        int node;
        node = src;
        for (int hop = 0; hop < 2; hop++) begin
            if ((node & 1) != (dst & 1)) begin
                node = node ^ 1;
            end else if ((node & 2) != (dst & 2)) begin
                node = node ^ 2;
            end
        end
        return node;
    endfunction

    function automatic int queue_index(input int src, input int dst, input int vc);
        return (src * NUM_NODES + dst) * NUM_VCS + vc;
    endfunction

    function automatic int total_errors();
        return cmp_errors + hold_errors + test_errors;
    endfunction

    // Sources inject only on a VC their port 0 buffer reports free
    always @(posedge clk) begin : drive_sources
        flit_t next_flit;
        int    vc;
        for (int n = 0; n < NUM_NODES; n++) begin
            data_ready_in[n] <= 1'b0;
            if (!rst && sent_idx[n] < stim_len[n]) begin
                next_flit = stim[n][sent_idx[n]];
                vc = int'(next_flit.metadata.vc);
                if (buffer_available[vc * NUM_NODES + n]) begin
                    in_flit[n]       <= next_flit;
                    data_ready_in[n] <= 1'b1;
                    sb_q[queue_index(n, int'(next_flit.metadata.dest), vc)].push_back(next_flit);
                    sent_idx[n]++;
                end
            end
        end
    end

    always @(posedge clk) begin : drive_sinks
        for (int n = 0; n < NUM_NODES; n++) begin
            packet_sent[n] <= !rst && !sink_blocked[n];
        end
    end

    // Every ejection pops its scoreboard queue
    always @(posedge clk) begin : compare
        flit_t got;
        flit_t expected;
        int    src;
        int    dst;
        int    q;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (!rst && data_ready_out[n] && packet_sent[n]) begin
                got = out[n];
                // Source node sits in the top payload bits
                src = int'(got.payload[PAYLOAD_W-1 -: NODE_W]);
                dst = int'(got.metadata.dest);
                q = queue_index(src, dst, int'(got.metadata.vc));
                rx_cnt++;
                if (n != expected_eject(src, dst)) begin
                    $display("Error at %0t: eject node of %h expected %0d got %0d",
                             $time, got, expected_eject(src, dst), n);
                    cmp_errors++;
                end
                if (sb_q[q].size() == 0) begin
                    $display("Flit %h left node %0d at %0t but was not pending",
                             got, n, $time);
                    cmp_errors++;
                end else begin
                    expected = sb_q[q].pop_front();
                    if (got != expected) begin
                        $display("Error at %0t: out[%0d] expected %h got %h",
                                 $time, n, expected, got);
                        cmp_errors++;
                    end
                end
            end
        end
    end

    // A flit not taken must still be there, unchanged, at the next edge
    always @(posedge clk) begin : hold_monitor
        for (int n = 0; n < NUM_NODES; n++) begin
            if (!rst && stall_valid[n]) begin
                if (!data_ready_out[n]) begin
                    $display("Error at %0t: data_ready_out[%0d] expected 1 got 0", $time, n);
                    hold_errors++;
                end else if (out[n] != stall_flit[n]) begin
                    $display("Error at %0t: out[%0d] expected %h got %h",
                             $time, n, stall_flit[n], out[n]);
                    hold_errors++;
                end
            end
            stall_valid[n] <= !rst && data_ready_out[n] && !packet_sent[n];
            stall_flit[n]  <= out[n];
        end
    end

    always @(posedge clk) begin : count_levels
        if (!rst) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (credit_granted[n]) begin
                    credit_cnt[n]++;
                end
            end
            for (int i = 0; i < NUM_NODES * 2; i++) begin
                if (!buffer_available[i]) begin
                    low_cnt[i]++;
                end
            end
        end
    end

    task automatic add_flit(input int src, input int dst, input int vc);
        flit_t f;
        f.metadata.dest = NODE_W'(dst);
        f.metadata.vc   = VC_W'(vc);
        f.payload       = {NODE_W'(src), (PAYLOAD_W-NODE_W)'(stim_len[src])};
        stim[src][stim_len[src]] = f;
        stim_len[src]++;
    endtask

    // Everything injected, ejected and no output still valid
    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int n = 0; n < NUM_NODES; n++) begin
                if (sent_idx[n] < stim_len[n] || data_ready_out[n]) begin
                    busy = 1'b1;
                end
            end
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (sb_q[q].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic check_level(input string name, input int idx, input logic expected,
                               input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s[%0d] expected %0b got %0b",
                     $time, name, idx, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test();
        err_base = total_errors();
        rx_base  = rx_cnt;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("Test %0d (%s) done, %0d errors", num, name, total_errors() - err_base);
    endtask

    initial begin : tests
        logic [31:0] r;
        int          low_base [NUM_NODES];
        logic        stalled;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        start_test();
        for (int n = 0; n < NUM_NODES; n++) begin
            check_level("data_ready_out", n, 1'b0, data_ready_out[n]);
            check_level("credit_granted", n, 1'b0, credit_granted[n]);
        end
        for (int i = 0; i < NUM_NODES * 2; i++) begin
            check_level("buffer_available", i, 1'b1, buffer_available[i]);
        end
        finish_test(1, "reset state");

        // Every pair, self included, on both VCs
        start_test();
        for (int s = 0; s < NUM_NODES; s++) begin
            for (int d = 0; d < NUM_NODES; d++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    add_flit(s, d, v);
                end
            end
        end
        wait_drain();
        check_count("received flits", ROUTE_FLITS, rx_cnt - rx_base);
        finish_test(2, "routing");

        start_test();
        for (int i = 0; i < RAND_PER_NODE; i++) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                r = $random(seed);
                add_flit(n, int'(r[1:0]), int'(r[2]));
            end
        end
        wait_drain();
        check_count("received flits", NUM_NODES * RAND_PER_NODE, rx_cnt - rx_base);
        finish_test(3, "random traffic");

        // Node 0 blocked, the other three flood it on VC 0
        start_test();
        sink_blocked[0] = 1'b1;
        for (int s = 1; s < NUM_NODES; s++) begin
            low_base[s] = low_cnt[s];
        end
        for (int i = 0; i < BP_PER_NODE; i++) begin
            for (int s = 1; s < NUM_NODES; s++) begin
                add_flit(s, 0, 0);
            end
        end
        stalled = 1'b0;
        while (!stalled) begin
            @(negedge clk);
            stalled = 1'b1;
            for (int s = 1; s < NUM_NODES; s++) begin
                if (low_cnt[s] == low_base[s]) begin
                    stalled = 1'b0;
                end
            end
        end
        repeat (BLOCK_HOLD) @(negedge clk);
        check_level("data_ready_out", 0, 1'b1, data_ready_out[0]);
        sink_blocked[0] = 1'b0;
        wait_drain();
        check_count("received flits", 3 * BP_PER_NODE, rx_cnt - rx_base);
        finish_test(4, "back-pressure");

        // Credit pulses count over the whole run
        start_test();
        for (int n = 0; n < NUM_NODES; n++) begin
            check_count($sformatf("credit_granted[%0d] pulses", n), sent_idx[n],
                        credit_cnt[n]);
        end
        finish_test(5, "injection credit");

        $display("Summary: 5 tests, %0d flits received, %0d errors", rx_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, traffic did not drain", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
common/noc_pkg.sv
common/switch_if.sv
switch/vc_buffer.sv
switch/switch_allocator.sv
switch/switch.sv
hw/switch_wrapper.sv
testbench/switch_wrapper_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = switch_wrapper_tb
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
